/* rtl/uart_pkg.sv */
package uart_pkg;

  // command word and frame geometry
  localparam int cmd_width   = 16;
  localparam int data_bits   = 8;
  localparam int frame_bits  = 11;
  localparam int read_word_w = 9;

  // field view of a command
  typedef struct packed {
    logic       rw;
    logic [6:0] addr;
    logic [7:0] wdata;
  } cmd_fields_t;

  // same word seen as fields or as two line bytes
  typedef union packed {
    cmd_fields_t                    fields;
    logic [1:0][data_bits-1:0]      bytes;
  } cmd_word_u;

endpackage

/* rtl/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx #(
  parameter int clks_per_bit = 434
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           tx_start,
  input  logic [uart_pkg::data_bits-1:0] tx_byte,
  output logic                           tx,
  output logic                           tx_busy,
  output logic                           tx_done
);

  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
  localparam logic [3:0] last_bit = 4'(uart_pkg::frame_bits - 1);

  logic [uart_pkg::frame_bits-1:0] shift_q;
  logic [cnt_w-1:0]                baud_cnt;
  logic [3:0]                      bit_cnt;
  logic                            busy_q;
  logic                            bit_end;

  assign bit_end = busy_q && (baud_cnt == last_cnt);
  // last cycle of the stop bit
  assign tx_done = bit_end && (bit_cnt == last_bit);
  assign tx_busy = busy_q;

  // line comes straight off a flop
  assign tx = shift_q[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_q  <= '1;
      busy_q   <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (tx_start && !busy_q) begin
      // stop, odd parity, data lsb first, start
      shift_q  <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
      busy_q   <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (busy_q) begin
      if (bit_end) begin
        baud_cnt <= '0;
        shift_q  <= {1'b1, shift_q[uart_pkg::frame_bits-1:1]};
        bit_cnt  <= bit_cnt + 4'd1;
        if (bit_cnt == last_bit) begin
          busy_q <= 1'b0;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

/* rtl/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx #(
  parameter int clks_per_bit = 434,
  parameter bit parity_check = 1'b1
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           rx_en,
  input  logic                           rx,
  output logic [uart_pkg::data_bits-1:0] rx_byte,
  output logic                           rx_parity_err,
  output logic                           rx_valid
);

  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);
  // index 0 is the start bit, the stop bit is last
  localparam logic [3:0] stop_idx = 4'(uart_pkg::frame_bits - 1);

  logic [2:0]                     sync_q;
  logic                           busy_q;
  logic [cnt_w-1:0]               cnt_q;
  logic [3:0]                     bit_idx;
  logic [uart_pkg::data_bits:0]   shift_q;
  logic                           valid_q;
  logic                           fall;
  logic                           sample;

  assign fall   = sync_q[2] & ~sync_q[1];
  assign sample = busy_q && (cnt_q == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q  <= '1;
      busy_q  <= 1'b0;
      cnt_q   <= '0;
      bit_idx <= '0;
      valid_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[1:0], rx};
      valid_q <= 1'b0;
      if (!busy_q) begin
        if (rx_en && fall) begin
          // half a bit to land on the middle of start
          busy_q  <= 1'b1;
          cnt_q   <= half_cnt;
          bit_idx <= '0;
        end
      end else if (sample) begin
        cnt_q   <= last_cnt;
        bit_idx <= bit_idx + 4'd1;
        if (bit_idx == stop_idx) begin
          busy_q  <= 1'b0;
          valid_q <= 1'b1;
        end
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // start falls out the bottom, parity ends up in the top bit
  always_ff @(posedge clk) begin
    if (sample && (bit_idx != stop_idx)) begin
      shift_q <= {sync_q[1], shift_q[uart_pkg::data_bits:1]};
    end
  end

  assign rx_byte  = shift_q[uart_pkg::data_bits-1:0];
  assign rx_valid = valid_q;

  // odd parity means data plus parity xor to one
  assign rx_parity_err = parity_check ? ~^shift_q : 1'b0;

endmodule

/* rtl/uart_cmd_ctrl.sv */
`timescale 1ns/1ns

module uart_cmd_ctrl (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [uart_pkg::cmd_width-1:0]   cmd_in,
  input  logic                             cmd_vld,
  output logic                             cmd_rdy,
  output logic                             tx_start,
  output logic [uart_pkg::data_bits-1:0]   tx_byte,
  input  logic                             tx_busy,
  input  logic                             tx_done,
  output logic                             rx_en,
  input  logic [uart_pkg::data_bits-1:0]   rx_byte,
  input  logic                             rx_parity_err,
  input  logic                             rx_valid,
  output logic [uart_pkg::read_word_w-1:0] read_data,
  output logic                             read_rdy
);

  localparam logic [2:0] st_idle       = 3'd0;
  localparam logic [2:0] st_send_hi    = 3'd1;
  localparam logic [2:0] st_send_lo    = 3'd2;
  localparam logic [2:0] st_wait_reply = 3'd3;
  localparam logic [2:0] st_done       = 3'd4;

  logic [2:0]                       state;
  logic                             pending;
  logic                             accept;
  uart_pkg::cmd_word_u              cmd_q;
  logic [uart_pkg::read_word_w-1:0] read_q;

  // done doubles as a ready slot so a new command can follow the reply
  assign cmd_rdy = (state == st_idle) || (state == st_done);
  assign accept  = cmd_vld && cmd_rdy;

  assign tx_start = pending && !tx_busy;
  assign tx_byte  = (state == st_send_lo) ? cmd_q.bytes[0] : cmd_q.bytes[1];

  assign rx_en     = (state == st_wait_reply);
  assign read_rdy  = (state == st_done);
  assign read_data = read_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_idle;
      pending <= 1'b0;
    end else begin
      if (tx_start) begin
        pending <= 1'b0;
      end
      case (state)
        st_idle, st_done: begin
          if (accept) begin
            state   <= st_send_hi;
            pending <= 1'b1;
          end else begin
            state <= st_idle;
          end
        end
        st_send_hi: begin
          if (tx_done) begin
            if (cmd_q.fields.rw) begin
              state   <= st_send_lo;
              pending <= 1'b1;
            end else begin
              state <= st_wait_reply;
            end
          end
        end
        st_send_lo: begin
          if (tx_done) begin
            state <= st_idle;
          end
        end
        st_wait_reply: begin
          // no timeout, a silent remote keeps us here
          if (rx_valid) begin
            state <= st_done;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
    if ((state == st_wait_reply) && rx_valid) begin
      read_q <= {rx_parity_err, rx_byte};
    end
  end

endmodule

/* rtl/uart.sv */
`timescale 1ns/1ns

module uart #(
  parameter int clk_hz       = 50000000,
  parameter int baud         = 115200,
  parameter bit parity_check = 1'b1
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [uart_pkg::cmd_width-1:0]   cmd_in,
  input  logic                             cmd_vld,
  output logic                             cmd_rdy,
  input  logic                             rx,
  output logic                             tx,
  output logic [uart_pkg::read_word_w-1:0] read_data,
  output logic                             read_rdy
);

  // integer bit time, rounding error is left to the line tolerance
  localparam int clks_per_bit = clk_hz / baud;

  logic                           tx_start;
  logic [uart_pkg::data_bits-1:0] tx_byte;
  logic                           tx_busy;
  logic                           tx_done;
  logic                           rx_en;
  logic [uart_pkg::data_bits-1:0] rx_byte;
  logic                           rx_parity_err;
  logic                           rx_valid;

  uart_cmd_ctrl ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_busy       (tx_busy),
    .tx_done       (tx_done),
    .rx_en         (rx_en),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err),
    .rx_valid      (rx_valid),
    .read_data     (read_data),
    .read_rdy      (read_rdy)
  );

  uart_tx #(
    .clks_per_bit (clks_per_bit)
  ) tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done)
  );

  uart_rx #(
    .clks_per_bit (clks_per_bit),
    .parity_check (parity_check)
  ) rx_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx_en         (rx_en),
    .rx            (rx),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err),
    .rx_valid      (rx_valid)
  );

endmodule

/* tests/uart_checker.sv */
`timescale 1ns/1ns

module uart_checker (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic read_rdy
);

  int fail_cnt = 0;

  // handshake drops right after a command is taken
  rdy_drops_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_vld && cmd_rdy |=> !cmd_rdy)
    else begin
      fail_cnt++;
      $error("cmd_rdy stayed high after a command was accepted");
    end

  read_rdy_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else begin
      fail_cnt++;
      $error("read_rdy was high for two cycles in a row");
    end

  // line idles while the bridge is free
  tx_idle_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx)
    else begin
      fail_cnt++;
      $error("tx was low while cmd_rdy was high");
    end

  read_follows_busy: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |-> !$past(cmd_rdy))
    else begin
      fail_cnt++;
      $error("read_rdy came while cmd_rdy was high the cycle before");
    end

endmodule

bind uart uart_checker chk_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy)
);

/* tests/uart_tb.sv */
`timescale 1ns/1ns

module uart_tb;

  localparam int clk_hz    = 50000000;
  localparam int baud      = 3125000;
  localparam int bit_clks  = clk_hz / baud;
  localparam int n_cmds    = 25;
  localparam int wr_cycles = 22 * bit_clks + 3;
  localparam int limit     = n_cmds * 40 * bit_clks + 1000;

  logic                             clk = 1'b0;
  logic                             rst_n;
  logic [uart_pkg::cmd_width-1:0]   cmd_in;
  logic                             cmd_vld;
  logic                             cmd_rdy;
  logic                             rx;
  logic                             tx;
  logic [uart_pkg::read_word_w-1:0] read_data;
  logic                             read_rdy;

  logic [31:0]                      lfsr_q = 32'h4cd6;
  logic [7:0]                       exp_bytes[$];
  int                               value_errs = 0;
  int                               frame_errs = 0;
  int                               read_cnt = 0;
  int                               reads_done = 0;
  logic [uart_pkg::read_word_w-1:0] last_read;
  logic                             rdy_at_read;

  uart #(
    .clk_hz       (clk_hz),
    .baud         (baud),
    .parity_check (1'b1)
  ) uart_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  always #10 clk = ~clk;

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else begin
        value_errs++;
        $error("ERROR signal=%s got=%h expected=%h", name, got, exp);
      end
  endtask

  // remote side of the tx line decoded at mid-bit
  initial begin : line_monitor
    logic [uart_pkg::frame_bits-1:0] frame;
    logic [7:0]                      want;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (tx === 1'b0) begin
        repeat (bit_clks / 2) @(negedge clk);
        for (int i = 0; i < uart_pkg::frame_bits; i++) begin
          frame[i] = tx;
          if (i < uart_pkg::frame_bits - 1) repeat (bit_clks) @(negedge clk);
        end
        assert (frame[0] == 1'b0)
          else begin
            frame_errs++;
            $error("start bit on tx was not low at mid-bit");
          end
        assert (frame[10] == 1'b1)
          else begin
            frame_errs++;
            $error("stop bit on tx was not high at mid-bit");
          end
        assert (^frame[9:1] == 1'b1)
          else begin
            frame_errs++;
            $error("frame on tx had even parity");
          end
        assert (exp_bytes.size() > 0)
          else begin
            frame_errs++;
            $error("frame on tx that no command asked for, byte %h", frame[8:1]);
          end
        if (exp_bytes.size() > 0) begin
          want = exp_bytes.pop_front();
          check_value("tx_byte", frame[8:1], want);
        end
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && read_rdy) begin
      read_cnt++;
      last_read   = read_data;
      rdy_at_read = cmd_rdy;
    end
  end

  task automatic issue(input logic [15:0] cmd);
    @(posedge clk);
    #2;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    while (!cmd_rdy) @(negedge clk);
    @(posedge clk);
    #2;
    cmd_vld = 1'b0;
  endtask

  // count from the accept edge to cmd_rdy seen high
  task automatic wait_write_done();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!cmd_rdy);
    check_value("cmd_rdy_cycles", cycles, wr_cycles);
    check_value("pending_frames", exp_bytes.size(), 0);
  endtask

  task automatic run_write(input logic [15:0] cmd);
    exp_bytes.push_back(cmd[15:8]);
    exp_bytes.push_back(cmd[7:0]);
    issue(cmd);
    wait_write_done();
  endtask

  task automatic send_reply(input logic [7:0] data, input logic bad);
    logic [uart_pkg::frame_bits-1:0] frame;
    frame = {1'b1, (~^data) ^ bad, data, 1'b0};
    for (int i = 0; i < uart_pkg::frame_bits; i++) begin
      @(posedge clk);
      #2;
      rx = frame[i];
      repeat (bit_clks - 1) @(posedge clk);
    end
  endtask

  task automatic run_read(input logic [15:0] cmd, input logic bad);
    logic [7:0] noise;
    logic [7:0] reply;
    int         gap;
    int         base;
    exp_bytes.push_back(cmd[15:8]);
    base = read_cnt;
    issue(cmd);
    while (exp_bytes.size() != 0) @(posedge clk);
    gap   = 1 + int'(rand_bits(3));
    noise = 8'(rand_bits(8));
    reply = {1'b0, cmd[14:8]} ^ noise;
    repeat (gap * bit_clks) @(posedge clk);
    send_reply(reply, bad);
    while (read_cnt == base) @(posedge clk);
    check_value("read_data", last_read, {bad, reply});
    check_value("cmd_rdy", rdy_at_read, 1'b1);
    reads_done++;
  endtask

  // cmd_vld stays up with a moving cmd_in while frames are in flight
  task automatic run_busy();
    logic [15:0] first;
    logic [15:0] next;
    int          cycles;
    first = 16'h8000 | 16'(rand_bits(16));
    exp_bytes.push_back(first[15:8]);
    exp_bytes.push_back(first[7:0]);
    @(posedge clk);
    #2;
    cmd_in  = first;
    cmd_vld = 1'b1;
    @(negedge clk);
    while (!cmd_rdy) @(negedge clk);
    @(posedge clk);
    cycles = 0;
    do begin
      #2;
      cmd_in = 16'h8000 | 16'(rand_bits(16));
      @(negedge clk);
      cycles++;
      if (!cmd_rdy) @(posedge clk);
    end while (!cmd_rdy);
    check_value("cmd_rdy_cycles", cycles, wr_cycles);
    check_value("pending_frames", exp_bytes.size(), 0);
    next = cmd_in;
    exp_bytes.push_back(next[15:8]);
    exp_bytes.push_back(next[7:0]);
    @(posedge clk);
    #2;
    cmd_vld = 1'b0;
    wait_write_done();
  endtask

  initial begin : watchdog
    repeat (limit) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display(">>> FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [15:0] cmd;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    repeat (20) begin
      @(negedge clk);
      check_value("tx", tx, 1'b1);
      check_value("cmd_rdy", cmd_rdy, 1'b1);
      check_value("read_rdy", read_rdy, 1'b0);
    end

    run_write(16'ha55a);
    run_read(16'h2c00, 1'b0);
    run_read(16'h1234, 1'b1);
    run_busy();

    for (int k = 0; k < 20; k++) begin
      cmd = 16'(rand_bits(uart_pkg::cmd_width));
      if (cmd[15]) begin
        run_write(cmd);
      end else begin
        run_read(cmd, 1'b0);
      end
    end

    repeat (2 * bit_clks) @(posedge clk);
    check_value("read_pulses", read_cnt, reads_done);

    $display("errors: value=%0d frame=%0d protocol=%0d",
             value_errs, frame_errs, uart_i.chk_i.fail_cnt);
    if (value_errs + frame_errs + uart_i.chk_i.fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* project.f */
rtl/uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_cmd_ctrl.sv
rtl/uart.sv
tests/uart_checker.sv
tests/uart_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the UART bridge testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module uart_tb \
  -f project.f \
  -o uart_sim

./obj_dir/uart_sim +verilator+error+limit+10000 2>&1 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"
exit 0
